//--- logic/cpu16_pkg.sv
package cpu16_pkg;

	// ------------------------------
	// word and register file
	// ------------------------------
	localparam int word_bits = 16;                   // set by the instruction encoding
	typedef logic [word_bits - 1 : 0] word_t;        // data or instruction word
	typedef logic [3 : 0] reg_idx_t;                 // 4-bit register index
	localparam int num_regs = 16;

	localparam reg_idx_t ip_idx     = 4'd12;         // instruction pointer
	localparam reg_idx_t sp_idx     = 4'd13;         // stack pointer
	localparam reg_idx_t bp_idx     = 4'd14;         // base pointer
	localparam reg_idx_t status_idx = 4'd15;         // status with the compare flags

	// compare flag positions in status
	localparam int flag_eq = 0;                      // also the condition bit
	localparam int flag_ne = 1;
	localparam int flag_gt = 2;
	localparam int flag_ge = 3;
	localparam int flag_lt = 4;
	localparam int flag_le = 5;

	// ------------------------------
	// sequencer and decode types
	// ------------------------------
	typedef enum logic [2 : 0] {
		FETCH, DECODE, LOAD_IMMVAL, EXEC, WRITE_MEM, HALT
	} cycle_t;

	typedef enum logic [1 : 0] {
		OP_REG0, OP_REG1, OP_REG1_IMM, OP_REG2
	} op_class_t;

	// codes 0 to 7 line up with reg2_op_t
	typedef enum logic [3 : 0] {
		ALU_MOV, ALU_ADD, ALU_SUB, ALU_SHL, ALU_SHR, ALU_CMP, ALU_AND, ALU_OR,
		ALU_BNOT, ALU_LNOT
	} alu_op_t;

	typedef enum logic [2 : 0] {
		R2_MOV, R2_ADD, R2_SUB, R2_SHL, R2_SHR, R2_CMP, R2_AND, R2_OR
	} reg2_op_t;

	typedef enum logic [2 : 0] {
		LDI, LDM, STM                                // immediate, load, store
	} reg1_imm_op_t;

	typedef enum logic [2 : 0] {
		JMP_COND, JMP_ABS, JMP_REL, CALL, BIT_NOT, LOG_NOT, PUSH, POP
	} reg1_op_t;

	typedef enum logic [4 : 0] {
		HALT_OP = 5'd0, NOP = 5'd1, RET = 5'd2,
		SEL_NE = 5'd4, SEL_GT = 5'd5, SEL_GE = 5'd6, SEL_LT = 5'd7, SEL_LE = 5'd8
	} reg0_op_t;

endpackage

//--- logic/cpu16_ifs.sv
// decoder inputs and registered fields
interface decode_if;
	cpu16_pkg::word_t instr_word;            // word from memory
	logic load;                              // capture strobe on fetch ack
	cpu16_pkg::op_class_t op_class;
	logic has_immval;                        // bit 13 of a register-less or one-register word
	cpu16_pkg::reg_idx_t reg_a;
	cpu16_pkg::reg_idx_t reg_b;
	logic [2 : 0] sub_op;                    // reg2, reg1 and reg1 imm groups
	logic [4 : 0] sys_op;                    // reg0 group

	modport sequencer (output instr_word, load,
		input op_class, has_immval, reg_a, reg_b, sub_op, sys_op);
	modport decoder (input instr_word, load,
		output op_class, has_immval, reg_a, reg_b, sub_op, sys_op);
endinterface

// register file access
interface regfile_if;
	cpu16_pkg::reg_idx_t rd_idx_a;
	cpu16_pkg::reg_idx_t rd_idx_b;
	cpu16_pkg::word_t rd_data_a;
	cpu16_pkg::word_t rd_data_b;
	logic wr_en;                             // general port that wins a clash
	cpu16_pkg::reg_idx_t wr_idx;
	cpu16_pkg::word_t wr_data;
	logic ip_wr;
	cpu16_pkg::word_t ip_next;
	logic sp_wr;
	cpu16_pkg::word_t sp_next;
	cpu16_pkg::word_t ip;
	cpu16_pkg::word_t sp;
	cpu16_pkg::word_t status;

	modport sequencer (output rd_idx_a, rd_idx_b, wr_en, wr_idx, wr_data,
		ip_wr, ip_next, sp_wr, sp_next,
		input rd_data_a, rd_data_b, ip, sp, status);
	modport regfile (input rd_idx_a, rd_idx_b, wr_en, wr_idx, wr_data,
		ip_wr, ip_next, sp_wr, sp_next,
		output rd_data_a, rd_data_b, ip, sp, status);
endinterface

// combinational alu
interface alu_if;
	cpu16_pkg::alu_op_t op;
	cpu16_pkg::word_t a;
	cpu16_pkg::word_t b;
	cpu16_pkg::word_t result;
	cpu16_pkg::word_t flags;                 // compare flags in status layout

	modport sequencer (output op, a, b, input result, flags);
	modport alu (input op, a, b, output result, flags);
endinterface

//--- logic/cpu16_decoder.sv
module cpu16_decoder (
	input logic in_clk,
	input logic in_rst,
	decode_if.decoder dec
);
	localparam int top_bit = cpu16_pkg::word_bits - 1;
	localparam int immval_bit = cpu16_pkg::word_bits - 3;

	cpu16_pkg::op_class_t cls;                   // class of the incoming word

	// 1x is reg2, 01 is reg1, 00 is reg0
	always_comb begin
		if (dec.instr_word[top_bit])
			cls = cpu16_pkg::OP_REG2;
		else if (dec.instr_word[top_bit - 1] && dec.instr_word[immval_bit])
			cls = cpu16_pkg::OP_REG1_IMM;
		else if (dec.instr_word[top_bit - 1])
			cls = cpu16_pkg::OP_REG1;
		else
			cls = cpu16_pkg::OP_REG0;
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			dec.op_class <= cpu16_pkg::OP_REG0;
			dec.has_immval <= 1'b0;
			dec.reg_a <= '0;
			dec.reg_b <= '0;
			dec.sub_op <= '0;
			dec.sys_op <= '0;
		end else if (dec.load) begin
			dec.op_class <= cls;
			dec.has_immval <= dec.instr_word[immval_bit] & ~dec.instr_word[top_bit];
			dec.reg_a <= (cls == cpu16_pkg::OP_REG2) ? dec.instr_word[7 : 4]
				: dec.instr_word[3 : 0];             // upper nibble only for reg2
			dec.reg_b <= dec.instr_word[3 : 0];
			dec.sub_op <= (cls == cpu16_pkg::OP_REG2) ? dec.instr_word[10 : 8]
				: dec.instr_word[6 : 4];
			dec.sys_op <= dec.instr_word[4 : 0];
		end
	end
endmodule

//--- logic/cpu16_regfile.sv
module cpu16_regfile #(
	parameter cpu16_pkg::word_t entry_addr = '0
) (
	input logic in_clk,
	input logic in_rst,
	regfile_if.regfile rf,
	output cpu16_pkg::word_t pc
);
	cpu16_pkg::word_t regs [cpu16_pkg::num_regs];

	// ------------------------------
	// write ports
	// ------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			regs <= '{default: '0};
			regs[cpu16_pkg::ip_idx] <= entry_addr;    // start of program
		end else begin
			if (rf.ip_wr)
				regs[cpu16_pkg::ip_idx] <= rf.ip_next;
			if (rf.sp_wr)
				regs[cpu16_pkg::sp_idx] <= rf.sp_next;
			if (rf.wr_en)
				regs[rf.wr_idx] <= rf.wr_data;         // last, so it wins
		end
	end

	// ------------------------------
	// read ports
	// ------------------------------
	assign rf.rd_data_a = regs[rf.rd_idx_a];
	assign rf.rd_data_b = regs[rf.rd_idx_b];
	assign rf.ip = regs[cpu16_pkg::ip_idx];
	assign rf.sp = regs[cpu16_pkg::sp_idx];
	assign rf.status = regs[cpu16_pkg::status_idx];

	assign pc = regs[cpu16_pkg::ip_idx];            // debug copy
endmodule

//--- logic/cpu16_alu.sv
module cpu16_alu (
	alu_if.alu alu
);
	cpu16_pkg::word_t flags;                          // unsigned compare of a and b

	always_comb begin
		flags = '0;
		flags[cpu16_pkg::flag_eq] = (alu.a == alu.b);
		flags[cpu16_pkg::flag_ne] = (alu.a != alu.b);
		flags[cpu16_pkg::flag_gt] = (alu.a > alu.b);
		flags[cpu16_pkg::flag_ge] = (alu.a >= alu.b);
		flags[cpu16_pkg::flag_lt] = (alu.a < alu.b);
		flags[cpu16_pkg::flag_le] = (alu.a <= alu.b);
	end

	// ------------------------------
	// result select
	// ------------------------------
	always_comb begin
		case (alu.op)
			cpu16_pkg::ALU_MOV:
				alu.result = alu.a;                      // written to reg_b by the sequencer
			cpu16_pkg::ALU_ADD:
				alu.result = alu.a + alu.b;
			cpu16_pkg::ALU_SUB:
				alu.result = alu.a - alu.b;
			cpu16_pkg::ALU_SHL:
				alu.result = alu.a << alu.b;             // full b as amount
			cpu16_pkg::ALU_SHR:
				alu.result = alu.a >> alu.b;
			cpu16_pkg::ALU_AND:
				alu.result = alu.a & alu.b;
			cpu16_pkg::ALU_OR:
				alu.result = alu.a | alu.b;
			cpu16_pkg::ALU_BNOT:
				alu.result = ~alu.a;
			cpu16_pkg::ALU_LNOT:
				alu.result = {{(cpu16_pkg::word_bits - 1){1'b0}}, (alu.a == '0)};
			default:
				alu.result = alu.a;
		endcase
	end

	assign alu.flags = flags;
endmodule

//--- logic/cpu16_sequencer.sv
module cpu16_sequencer #(
	parameter int addr_bits = 16
) (
	input logic in_clk,
	input logic in_rst,
	input logic mem_ack,
	input cpu16_pkg::word_t mem_rdata,
	output logic mem_req,
	output logic mem_write,
	output logic [addr_bits - 1 : 0] mem_addr,
	output cpu16_pkg::word_t mem_wdata,
	output cpu16_pkg::word_t instr,
	decode_if.sequencer dec,
	regfile_if.sequencer rf,
	alu_if.sequencer alu
);
	cpu16_pkg::cycle_t state, next_state;
	logic subcycle, next_subcycle;                       // set while waiting for ack
	cpu16_pkg::word_t immval, next_immval;
	cpu16_pkg::word_t next_instr, next_wdata;
	logic [addr_bits - 1 : 0] next_addr;
	logic next_req, next_write;

	cpu16_pkg::reg2_op_t r2_op;
	cpu16_pkg::reg1_imm_op_t ri_op;
	cpu16_pkg::reg1_op_t r1_op;
	cpu16_pkg::reg0_op_t r0_op;
	cpu16_pkg::word_t sp_down;                           // push target
	logic sel_bit;                                       // flag picked by a select

	// low bits of a word as address
	function automatic logic [addr_bits - 1 : 0] to_addr(input cpu16_pkg::word_t w);
		return w[addr_bits - 1 : 0];
	endfunction

	assign r2_op = cpu16_pkg::reg2_op_t'(dec.sub_op);
	assign ri_op = cpu16_pkg::reg1_imm_op_t'(dec.sub_op);
	assign r1_op = cpu16_pkg::reg1_op_t'(dec.sub_op);
	assign r0_op = cpu16_pkg::reg0_op_t'(dec.sys_op);
	assign sp_down = rf.sp - 1'b1;

	assign dec.instr_word = mem_rdata;
	assign dec.load = (state == cpu16_pkg::FETCH) && subcycle && mem_ack;
	assign rf.rd_idx_a = dec.reg_a;
	assign rf.rd_idx_b = dec.reg_b;
	assign alu.a = rf.rd_data_a;
	assign alu.b = rf.rd_data_b;

	// alu function and condition flag
	always_comb begin
		if (dec.op_class != cpu16_pkg::OP_REG1)
			alu.op = cpu16_pkg::alu_op_t'({1'b0, dec.sub_op});
		else if (r1_op == cpu16_pkg::LOG_NOT)
			alu.op = cpu16_pkg::ALU_LNOT;
		else
			alu.op = cpu16_pkg::ALU_BNOT;
		case (r0_op)
			cpu16_pkg::SEL_NE: sel_bit = rf.status[cpu16_pkg::flag_ne];
			cpu16_pkg::SEL_GT: sel_bit = rf.status[cpu16_pkg::flag_gt];
			cpu16_pkg::SEL_GE: sel_bit = rf.status[cpu16_pkg::flag_ge];
			cpu16_pkg::SEL_LT: sel_bit = rf.status[cpu16_pkg::flag_lt];
			default: sel_bit = rf.status[cpu16_pkg::flag_le];
		endcase
	end

	// ------------------------------
	// state registers
	// ------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= cpu16_pkg::FETCH;
			subcycle <= 1'b0;
			instr <= '0;
			mem_req <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			state <= next_state;
			subcycle <= next_subcycle;
			instr <= next_instr;
			mem_req <= next_req;
			mem_write <= next_write;
		end
	end

	always_ff @(posedge in_clk) begin
		immval <= next_immval;
		mem_addr <= next_addr;
		mem_wdata <= next_wdata;
	end

	// ------------------------------
	// instruction cycle
	// ------------------------------
	always_comb begin
		next_state = state;
		next_subcycle = subcycle;
		next_instr = instr;
		next_immval = immval;
		next_addr = mem_addr;
		next_wdata = mem_wdata;
		next_req = 1'b0;                                 // read strobe is a pulse
		next_write = 1'b0;
		rf.wr_en = 1'b0;
		rf.wr_idx = dec.reg_a;
		rf.wr_data = alu.result;
		rf.ip_wr = 1'b0;
		rf.ip_next = rf.ip + 1'b1;                       // advance by default
		rf.sp_wr = 1'b0;
		rf.sp_next = sp_down;

		unique case (state)
			cpu16_pkg::FETCH, cpu16_pkg::LOAD_IMMVAL: begin
				if (!subcycle) begin                     // read at ip and step ip
					next_addr = to_addr(rf.ip);
					next_req = 1'b1;
					next_subcycle = 1'b1;
					rf.ip_wr = 1'b1;
				end else if (mem_ack && state == cpu16_pkg::FETCH) begin
					next_instr = mem_rdata;
					next_subcycle = 1'b0;
					next_state = cpu16_pkg::DECODE;
				end else if (mem_ack) begin
					next_immval = mem_rdata;
					next_subcycle = 1'b0;
					next_state = cpu16_pkg::EXEC;
				end
			end

			cpu16_pkg::DECODE:
				next_state = (dec.op_class == cpu16_pkg::OP_REG1_IMM) ? cpu16_pkg::LOAD_IMMVAL
					: cpu16_pkg::EXEC;

			cpu16_pkg::WRITE_MEM: begin
				next_req = !mem_ack;                     // hold until ack
				next_write = !mem_ack;
				if (mem_ack)
					next_state = cpu16_pkg::FETCH;
			end

			cpu16_pkg::EXEC: begin
				next_state = cpu16_pkg::FETCH;           // most ops take one cycle
				case (dec.op_class)
					cpu16_pkg::OP_REG2: begin
						rf.wr_en = 1'b1;
						if (r2_op == cpu16_pkg::R2_MOV)
							rf.wr_idx = dec.reg_b;       // a into b
						if (r2_op == cpu16_pkg::R2_CMP) begin
							rf.wr_idx = cpu16_pkg::status_idx;
							rf.wr_data = alu.flags;
						end
					end

					cpu16_pkg::OP_REG1_IMM: begin
						case (ri_op)
							cpu16_pkg::LDI: begin
								rf.wr_en = 1'b1;
								rf.wr_data = immval;
							end
							cpu16_pkg::LDM: begin
								if (!subcycle) begin
									next_addr = to_addr(immval);
									next_req = 1'b1;
									next_subcycle = 1'b1;
									next_state = cpu16_pkg::EXEC;
								end else if (mem_ack) begin
									rf.wr_en = 1'b1;
									rf.wr_data = mem_rdata;
									next_subcycle = 1'b0;
								end else
									next_state = cpu16_pkg::EXEC;
							end
							cpu16_pkg::STM: begin
								next_addr = to_addr(immval);
								next_wdata = rf.rd_data_a;
								next_req = 1'b1;
								next_write = 1'b1;
								next_state = cpu16_pkg::WRITE_MEM;
							end
							default:
								next_state = cpu16_pkg::HALT;   // unknown opcode
						endcase
					end

					cpu16_pkg::OP_REG1: begin
						case (r1_op)
							cpu16_pkg::JMP_COND: begin
								rf.ip_wr = rf.status[0];    // condition bit
								rf.ip_next = rf.rd_data_a;
							end
							cpu16_pkg::JMP_ABS: begin
								rf.ip_wr = 1'b1;
								rf.ip_next = rf.rd_data_a;
							end
							cpu16_pkg::JMP_REL: begin
								rf.ip_wr = 1'b1;
								rf.ip_next = rf.ip + rf.rd_data_a;   // ip already advanced
							end
							cpu16_pkg::CALL, cpu16_pkg::PUSH: begin
								rf.sp_wr = 1'b1;
								rf.ip_wr = (r1_op == cpu16_pkg::CALL);
								rf.ip_next = rf.rd_data_a;
								next_addr = to_addr(sp_down);
								next_wdata = (r1_op == cpu16_pkg::CALL) ? rf.ip : rf.rd_data_a;
								next_req = 1'b1;
								next_write = 1'b1;
								next_state = cpu16_pkg::WRITE_MEM;
							end
							cpu16_pkg::BIT_NOT, cpu16_pkg::LOG_NOT:
								rf.wr_en = 1'b1;
							default: begin                  // pop
								if (!subcycle) begin
									rf.sp_wr = 1'b1;
									rf.sp_next = rf.sp + 1'b1;
									next_addr = to_addr(rf.sp);
									next_req = 1'b1;
									next_subcycle = 1'b1;
									next_state = cpu16_pkg::EXEC;
								end else if (mem_ack) begin
									rf.wr_en = 1'b1;
									rf.wr_data = mem_rdata;
									next_subcycle = 1'b0;
								end else
									next_state = cpu16_pkg::EXEC;
							end
						endcase
					end

					default: begin                      // reg0 group
						case (r0_op)
							cpu16_pkg::NOP: ;
							cpu16_pkg::RET: begin
								if (!subcycle) begin
									rf.sp_wr = 1'b1;
									rf.sp_next = rf.sp + 1'b1;
									next_addr = to_addr(rf.sp);
									next_req = 1'b1;
									next_subcycle = 1'b1;
									next_state = cpu16_pkg::EXEC;
								end else if (mem_ack) begin
									rf.ip_wr = 1'b1;
									rf.ip_next = mem_rdata;
									next_subcycle = 1'b0;
								end else
									next_state = cpu16_pkg::EXEC;
							end
							cpu16_pkg::SEL_NE, cpu16_pkg::SEL_GT, cpu16_pkg::SEL_GE,
							cpu16_pkg::SEL_LT, cpu16_pkg::SEL_LE: begin
								rf.wr_en = 1'b1;
								rf.wr_idx = cpu16_pkg::status_idx;
								rf.wr_data = {rf.status[cpu16_pkg::word_bits - 1 : 1], sel_bit};
							end
							default:
								next_state = cpu16_pkg::HALT;   // halt and unknown
						endcase
						if (dec.has_immval)
							next_state = cpu16_pkg::HALT;   // no reg0 immediate ops
					end
				endcase
			end

			default:
				next_state = cpu16_pkg::HALT;            // only reset leaves
		endcase
	end
endmodule

//--- logic/cpu16_core.sv
module cpu16_core #(
	parameter int addr_bits = 16,
	parameter cpu16_pkg::word_t entry_addr = '0
) (
	input logic in_clk,
	input logic in_rst,

	// memory bus
	input logic mem_ack,
	input cpu16_pkg::word_t mem_rdata,
	output logic mem_req,
	output logic mem_write,
	output logic [addr_bits - 1 : 0] mem_addr,
	output cpu16_pkg::word_t mem_wdata,

	// debug
	output cpu16_pkg::word_t instr,               // last fetched word
	output cpu16_pkg::word_t pc                   // instruction pointer
);
	decode_if dec_bus ();
	regfile_if rf_bus ();
	alu_if alu_bus ();

	cpu16_sequencer #(
		.addr_bits(addr_bits)
	) u_seq (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.instr(instr),
		.dec(dec_bus),
		.rf(rf_bus),
		.alu(alu_bus)
	);

	cpu16_decoder u_dec (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.dec(dec_bus)
	);

	cpu16_regfile #(
		.entry_addr(entry_addr)
	) u_rf (
		.in_clk(in_clk),
		.in_rst(in_rst),
		.rf(rf_bus),
		.pc(pc)
	);

	cpu16_alu u_alu (
		.alu(alu_bus)
	);
endmodule

//--- verification/cpu16_sva.sv
module cpu16_sva #(
	parameter int addr_bits = 16
) (
	input logic in_clk,
	input logic in_rst,
	input logic mem_req,
	input logic mem_write,
	input logic mem_ack,
	input logic [addr_bits - 1 : 0] mem_addr,
	input cpu16_pkg::word_t mem_wdata
);
	timeunit 1ns;
	timeprecision 100ps;

	// ------------------------------
	// memory bus rules
	// ------------------------------
	write_has_req: assert property (@(posedge in_clk) disable iff (in_rst)
		mem_write |-> mem_req)
		else $error("write strobe without request strobe");

	// pending write holds everything until ack
	write_held: assert property (@(posedge in_clk) disable iff (in_rst)
		(mem_write && !mem_ack) |=> (mem_req && mem_write && $stable(mem_addr)
			&& $stable(mem_wdata)))
		else $error("write strobes, address or data changed before ack");

	idle_after_reset: assert property (@(posedge in_clk)
		$fell(in_rst) |-> (!mem_req && !mem_write))
		else $error("strobes high right after reset");
endmodule

bind cpu16_core cpu16_sva #(.addr_bits(addr_bits)) u_sva (
	.in_clk(in_clk),
	.in_rst(in_rst),
	.mem_req(mem_req),
	.mem_write(mem_write),
	.mem_ack(mem_ack),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata)
);

//--- verification/cpu16_tb.sv
module cpu16_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic in_clk, in_rst, mem_ack, mem_req, mem_write;
	logic [15 : 0] mem_rdata, mem_addr, mem_wdata, instr, pc;
	logic [15 : 0] mem [256];                        // 256-word memory model
	logic [15 : 0] prog [$];
	logic [15 : 0] exp_addr [$], exp_data [$], store_addr [$], store_data [$];
	logic [15 : 0] first_addr, a, b, v, v2;
	logic first_write, mw;
	logic [7 : 0] ma;
	logic [15 : 0] md;
	int errors = 0, tests_run = 0, req_count = 0, start_errors, delay, q, n;
	string test_name;

	cpu16_core dut (.in_clk(in_clk), .in_rst(in_rst), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .instr(instr), .pc(pc));

	initial begin
		in_clk = 1'b0;
		forever #5 in_clk = ~in_clk;
	end

	// ------------------------------
	// instruction encoding
	// ------------------------------
	function automatic logic [15 : 0] reg2_word(int op, int ra, int rb);
		return 16'(32'h8000 | (op << 8) | (ra << 4) | rb);
	endfunction
	function automatic logic [15 : 0] imm_word(int op, int ra);
		return 16'(32'h6000 | (op << 4) | ra);     // immediate word follows
	endfunction
	function automatic logic [15 : 0] reg1_word(int op, int ra);
		return 16'(32'h4000 | (op << 4) | ra);
	endfunction
	function automatic logic [15 : 0] fill(int i);
		return {8'(i) ^ 8'h5a, 8'(i)};              // unused words
	endfunction

	// expected results
	function automatic logic [15 : 0] alu_model(int op, logic [15 : 0] x, logic [15 : 0] y);
		case (op)
			0: return x;                             // transfer lands in reg b
			1: return x + y;
			2: return x - y;
			3: return x << y;
			4: return x >> y;
			5: return {10'd0, x <= y, x < y, x >= y, x > y, x != y, x == y};
			6: return x & y;
			default: return x | y;
		endcase
	endfunction
	function automatic logic cond_flag(int s, logic [15 : 0] x, logic [15 : 0] y);
		case (s)
			4: return x != y;
			5: return x > y;
			6: return x >= y;
			7: return x < y;
			default: return x <= y;
		endcase
	endfunction

	task automatic put(int w);
		prog.push_back(16'(w));
	endtask
	task automatic load_imm(int r, int val);
		put(imm_word(cpu16_pkg::LDI, r));
		put(val);
	endtask
	task automatic store_reg(int r, int addr);
		put(imm_word(cpu16_pkg::STM, r));
		put(addr);
	endtask
	task automatic add_store(int addr, logic [15 : 0] d);
		exp_addr.push_back(16'(addr));
		exp_data.push_back(d);
	endtask

	task automatic check_value(string what, logic [15 : 0] e, logic [15 : 0] act);
		assert (e == act) else begin
			$display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, e, act);
			errors++;
		end
	endtask

	// ------------------------------
	// memory model with 0 to 3 cycles of delay
	// ------------------------------
	initial begin
		mem_ack = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge in_clk);
			mem_ack = 1'b0;
			if (!in_rst && mem_req) begin
				ma = mem_addr[7 : 0];
				mw = mem_write;
				md = mem_wdata;
				if (req_count == 0) begin
					first_addr = mem_addr;
					first_write = mw;
				end
				req_count++;
				delay = $urandom % 4;
				repeat (delay) @(negedge in_clk);
				if (mw) begin
					mem[ma] = md;
					store_addr.push_back({8'd0, ma});
					store_data.push_back(md);
				end else
					mem_rdata = mem[ma];
				mem_ack = 1'b1;
			end
		end
	end

	// load, reset, run until the bus goes quiet
	task automatic run_program();
		int idle;
		int cycles;
		for (int i = 0; i < 256; i++)
			mem[i] = fill(i);
		foreach (prog[i])
			mem[i] = prog[i];
		store_addr.delete();
		store_data.delete();
		req_count = 0;
		in_rst = 1'b1;
		repeat (4) @(negedge in_clk);
		in_rst = 1'b0;
		idle = 0;
		cycles = 0;
		while (idle < 16 && cycles < 3000) begin
			@(negedge in_clk);
			cycles++;
			idle = (mem_req || mem_ack) ? 0 : idle + 1;
		end
		if (idle < 16) begin
			$display("Test %s timed out: the core never halted", test_name);
			errors++;
		end
	endtask

	task automatic finish_test();
		check_value("store count", 16'(exp_addr.size()), 16'(store_addr.size()));
		for (int i = 0; i < exp_addr.size() && i < store_addr.size(); i++) begin
			check_value($sformatf("store %0d address", i), exp_addr[i], store_addr[i]);
			check_value($sformatf("store %0d data", i), exp_data[i], store_data[i]);
		end
		$display("test %s done, %0d errors", test_name, errors - start_errors);
		tests_run++;
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic begin_test(string name);
		test_name = name;
		start_errors = errors;
	endtask

	initial begin
		in_rst = 1'b1;
		void'($urandom(32'h6c8ba60d));

		begin_test("reset_fetch");
		v = 16'($urandom);
		load_imm(1, v);
		store_reg(1, 'h80);
		put(cpu16_pkg::HALT_OP);
		add_store('h80, v);
		run_program();
		check_value("first address", 16'h0000, first_addr);
		check_value("first is read", 16'd0, {15'd0, first_write});
		check_value("pc", 16'd5, pc);
		finish_test();

		begin_test("reg2_ops");
		for (int op = 0; op < 8; op++) begin
			a = 16'($urandom);
			b = (op == 3 || op == 4) ? 16'($urandom % 16) : 16'($urandom);
			load_imm(1, a);
			load_imm(2, b);
			put(reg2_word(op, 1, 2));
			store_reg(op == 0 ? 2 : (op == 5 ? 15 : 1), 'h80 + op);
			add_store('h80 + op, alu_model(op, a, b));
		end
		put(cpu16_pkg::HALT_OP);
		run_program();
		finish_test();

		begin_test("cond_jumps");
		for (int k = 0; k < 2; k++) begin
			a = 16'($urandom);
			b = k ? a : 16'($urandom);                 // second pass hits equal
			load_imm(1, a);
			load_imm(2, b);
			put(reg2_word(cpu16_pkg::R2_CMP, 1, 2));
			for (int s = 4; s <= 8; s++) begin
				put(s);
				load_imm(5, 1);
				load_imm(3, prog.size() + 5);
				put(reg1_word(cpu16_pkg::JMP_COND, 3));
				load_imm(5, 0);                        // skipped if taken
				store_reg(5, 'ha0 + k * 8 + s);
				add_store('ha0 + k * 8 + s, {15'd0, cond_flag(s, a, b)});
			end
		end
		load_imm(5, 'h1234);
		load_imm(3, prog.size() + 5);
		put(reg1_word(cpu16_pkg::JMP_ABS, 3));
		load_imm(5, 'hdead);
		store_reg(5, 'hb0);
		load_imm(3, 2);
		put(reg1_word(cpu16_pkg::JMP_REL, 3));
		load_imm(5, 'hbeef);
		store_reg(5, 'hb1);
		put(cpu16_pkg::HALT_OP);
		add_store('hb0, 16'h1234);
		add_store('hb1, 16'h1234);
		run_program();
		finish_test();

		begin_test("stack");
		v = 16'($urandom);
		v2 = 16'($urandom);
		load_imm(13, 'hf0);
		load_imm(1, v);
		load_imm(2, v2);
		put(reg1_word(cpu16_pkg::PUSH, 1));
		put(reg1_word(cpu16_pkg::PUSH, 2));
		put(reg1_word(cpu16_pkg::POP, 3));
		put(reg1_word(cpu16_pkg::POP, 4));
		store_reg(3, 'hc0);
		store_reg(4, 'hc1);
		q = prog.size();
		load_imm(6, q + 6);
		put(reg1_word(cpu16_pkg::CALL, 6));
		store_reg(7, 'hc2);                            // return lands here
		put(cpu16_pkg::HALT_OP);
		load_imm(7, 'h5a5a);
		put(cpu16_pkg::RET);
		add_store('hef, v);
		add_store('hee, v2);
		add_store('hc0, v2);
		add_store('hc1, v);
		add_store('hef, 16'(q + 3));
		add_store('hc2, 16'h5a5a);
		run_program();
		finish_test();

		begin_test("load_not");
		v = fill('h90);
		put(imm_word(cpu16_pkg::LDM, 1));
		put('h90);
		store_reg(1, 'h80);
		put(reg1_word(cpu16_pkg::BIT_NOT, 1));
		store_reg(1, 'h81);
		put(reg1_word(cpu16_pkg::LOG_NOT, 1));
		store_reg(1, 'h82);
		load_imm(2, 0);
		put(reg1_word(cpu16_pkg::LOG_NOT, 2));
		store_reg(2, 'h83);
		put(cpu16_pkg::HALT_OP);
		add_store('h80, v);
		add_store('h81, ~v);
		add_store('h82, {15'd0, ~v == 16'd0});
		add_store('h83, 16'd1);
		run_program();
		finish_test();

		begin_test("unknown_op");
		load_imm(1, 7);
		store_reg(1, 'h80);
		put('h0003);                                   // undefined reg0 code
		load_imm(1, 9);
		store_reg(1, 'h81);
		add_store('h80, 16'd7);
		run_program();
		n = req_count;
		repeat (50) @(negedge in_clk);
		check_value("requests after halt", 16'(n), 16'(req_count));
		check_value("instr", 16'h0003, instr);
		finish_test();

		$display("tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end
endmodule

//--- cpu16.f
logic/cpu16_pkg.sv
logic/cpu16_ifs.sv
logic/cpu16_decoder.sv
logic/cpu16_regfile.sv
logic/cpu16_alu.sv
logic/cpu16_sequencer.sv
logic/cpu16_core.sv
verification/cpu16_sva.sv
verification/cpu16_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpu16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpu16.f --top-module cpu16_tb -o cpu16_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/cpu16_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
	exit 0
fi
exit 1
